// File: Makefile
VERILATOR ?= verilator
TOP       ?= decodeExecuteTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only if the testbench printed its pass line
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: hw/alu.sv
`default_nettype none

module alu (
    input  logic [rvDecodePkg::XLEN-1:0] srcA,
    input  logic [rvDecodePkg::XLEN-1:0] srcB,
    input  rvDecodePkg::aluCtrlT         aluCtrl,
    input  rvDecodePkg::branchCondT      branchCond,
    output logic [rvDecodePkg::XLEN-1:0] aluResult,
    output logic                         flagE     // branch condition holds
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;
    logic       equal;

    assign shamt      = srcB[4:0]; // rv32 shift amount
    assign ltSigned   = $signed(srcA) < $signed(srcB);
    assign ltUnsigned = srcA < srcB;
    assign equal      = srcA == srcB;

    always_comb begin
        case (aluCtrl)
            rvDecodePkg::ALU_ADD:   aluResult = srcA + srcB;
            rvDecodePkg::ALU_SUB:   aluResult = srcA - srcB;
            rvDecodePkg::ALU_SLL:   aluResult = srcA << shamt;
            rvDecodePkg::ALU_SLT:   aluResult = {{(rvDecodePkg::XLEN-1){1'b0}}, ltSigned};
            rvDecodePkg::ALU_SLTU:  aluResult = {{(rvDecodePkg::XLEN-1){1'b0}}, ltUnsigned};
            rvDecodePkg::ALU_XOR:   aluResult = srcA ^ srcB;
            rvDecodePkg::ALU_SRL:   aluResult = srcA >> shamt;
            rvDecodePkg::ALU_SRA:   aluResult = $unsigned($signed(srcA) >>> shamt);
            rvDecodePkg::ALU_OR:    aluResult = srcA | srcB;
            rvDecodePkg::ALU_AND:   aluResult = srcA & srcB;
            rvDecodePkg::ALU_PASSB: aluResult = srcB; // lui
            default:                aluResult = '0;
        endcase
    end

    // comparator ignores aluCtrl and control reads it only on branches
    always_comb begin
        case (branchCond)
            rvDecodePkg::BR_EQ:  flagE = equal;
            rvDecodePkg::BR_NE:  flagE = !equal;
            rvDecodePkg::BR_LT:  flagE = ltSigned;
            rvDecodePkg::BR_GE:  flagE = !ltSigned;
            rvDecodePkg::BR_LTU: flagE = ltUnsigned;
            rvDecodePkg::BR_GEU: flagE = !ltUnsigned;
            default:             flagE = 1'b0; // funct3 010/011 undefined
        endcase
    end

endmodule

`default_nettype wire

// File: hw/aluDecode.sv
`default_nettype none

module aluDecode (
    input  rvDecodePkg::aluOpT      aluOp,
    input  logic [2:0]              funct3,
    input  logic                    funct7b5,   // sub / sra select
    output rvDecodePkg::aluCtrlT    aluCtrl,
    output rvDecodePkg::branchCondT branchCond
);

    rvDecodePkg::aluCtrlT funct3Op; // shared r / i decode

    always_comb begin
        case (funct3)
            3'b000:  funct3Op = rvDecodePkg::ALU_ADD;
            3'b001:  funct3Op = rvDecodePkg::ALU_SLL;
            3'b010:  funct3Op = rvDecodePkg::ALU_SLT;
            3'b011:  funct3Op = rvDecodePkg::ALU_SLTU;
            3'b100:  funct3Op = rvDecodePkg::ALU_XOR;
            3'b101:  funct3Op = funct7b5 ? rvDecodePkg::ALU_SRA : rvDecodePkg::ALU_SRL;
            3'b110:  funct3Op = rvDecodePkg::ALU_OR;
            default: funct3Op = rvDecodePkg::ALU_AND;
        endcase
    end

    always_comb begin
        branchCond = rvDecodePkg::BR_EQ; // ignored outside branches
        case (aluOp)
            rvDecodePkg::ALUOP_R: begin
                // funct7b5 also picks sub on funct3 000
                if (funct3 == 3'b000 && funct7b5) begin
                    aluCtrl = rvDecodePkg::ALU_SUB;
                end else begin
                    aluCtrl = funct3Op;
                end
            end
            rvDecodePkg::ALUOP_I: begin
                aluCtrl = funct3Op; // no subi, so add stays add
            end
            rvDecodePkg::ALUOP_BRANCH: begin
                aluCtrl    = rvDecodePkg::ALU_SUB;
                branchCond = rvDecodePkg::branchCondT'(funct3);
            end
            rvDecodePkg::ALUOP_LUI: begin
                aluCtrl = rvDecodePkg::ALU_PASSB;
            end
            default: begin
                aluCtrl = rvDecodePkg::ALU_ADD; // load, store, jump, auipc
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/control.sv
`default_nettype none

module control (
    input  logic [6:0]        opcodeD, // instr[6:0]
    input  logic              flagE,   // branch compare from alu
    output rvDecodePkg::ctrlT ctrlD
);

    always_comb begin
        // defaults are the unknown opcode decode
        ctrlD.pcSrc     = rvDecodePkg::PC_PLUS4;
        ctrlD.resultSrc = rvDecodePkg::RES_ALU;
        ctrlD.memWrite  = 1'b0;
        ctrlD.aluSrc    = 1'b0;
        ctrlD.immSrc    = rvDecodePkg::IMM_I;
        ctrlD.regWrite  = 1'b0;
        ctrlD.aluOp     = rvDecodePkg::ALUOP_R;

        case (opcodeD)
            rvDecodePkg::OP_R: begin
                ctrlD.regWrite = 1'b1; // rs1 op rs2
            end
            rvDecodePkg::OP_IMM: begin
                ctrlD.aluOp    = rvDecodePkg::ALUOP_I;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.regWrite = 1'b1;
            end
            rvDecodePkg::OP_LOAD: begin
                ctrlD.aluOp     = rvDecodePkg::ALUOP_LOAD;
                ctrlD.resultSrc = rvDecodePkg::RES_MEM; // alu gives address
                ctrlD.aluSrc    = 1'b1;
                ctrlD.regWrite  = 1'b1;
            end
            rvDecodePkg::OP_STORE: begin
                ctrlD.aluOp    = rvDecodePkg::ALUOP_STORE;
                ctrlD.memWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.immSrc   = rvDecodePkg::IMM_S;
            end
            rvDecodePkg::OP_BRANCH: begin
                ctrlD.aluOp  = rvDecodePkg::ALUOP_BRANCH;
                ctrlD.immSrc = rvDecodePkg::IMM_B; // compares rs1 with rs2
                ctrlD.pcSrc  = flagE ? rvDecodePkg::PC_TARGET : rvDecodePkg::PC_PLUS4;
            end
            rvDecodePkg::OP_JAL: begin
                ctrlD.aluOp     = rvDecodePkg::ALUOP_JUMP;
                ctrlD.resultSrc = rvDecodePkg::RES_PC4; // link
                ctrlD.aluSrc    = 1'b1;
                ctrlD.immSrc    = rvDecodePkg::IMM_J;
                ctrlD.regWrite  = 1'b1;
                ctrlD.pcSrc     = rvDecodePkg::PC_TARGET;
            end
            rvDecodePkg::OP_JALR: begin
                ctrlD.aluOp     = rvDecodePkg::ALUOP_JUMP;
                ctrlD.resultSrc = rvDecodePkg::RES_PC4;
                ctrlD.aluSrc    = 1'b1;
                ctrlD.immSrc    = rvDecodePkg::IMM_I; // rs1 + i-imm
                ctrlD.regWrite  = 1'b1;
                ctrlD.pcSrc     = rvDecodePkg::PC_ALU;
            end
            rvDecodePkg::OP_LUI: begin
                ctrlD.aluOp    = rvDecodePkg::ALUOP_LUI; // alu passes imm
                ctrlD.aluSrc   = 1'b1;
                ctrlD.immSrc   = rvDecodePkg::IMM_U;
                ctrlD.regWrite = 1'b1;
            end
            rvDecodePkg::OP_AUIPC: begin
                ctrlD.aluOp     = rvDecodePkg::ALUOP_AUIPC;
                ctrlD.resultSrc = rvDecodePkg::RES_TARGET; // pc + u-imm
                ctrlD.aluSrc    = 1'b1;
                ctrlD.immSrc    = rvDecodePkg::IMM_U;
                ctrlD.regWrite  = 1'b1;
            end
            default: begin
                ctrlD.aluOp = rvDecodePkg::ALUOP_R; // keep defaults
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/decodeExecute.sv
`default_nettype none

module decodeExecute (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inValid,
    input  rvDecodePkg::instrT           instr,
    input  logic [rvDecodePkg::XLEN-1:0] rs1Data,
    input  logic [rvDecodePkg::XLEN-1:0] rs2Data,
    input  logic [rvDecodePkg::XLEN-1:0] pc,
    output rvDecodePkg::stageT           stage
);

    rvDecodePkg::ctrlT              ctrlD;
    rvDecodePkg::aluCtrlT           aluCtrl;
    rvDecodePkg::branchCondT        branchCond;
    logic [rvDecodePkg::XLEN-1:0]   immExt;
    logic [rvDecodePkg::XLEN-1:0]   srcB;
    logic [rvDecodePkg::XLEN-1:0]   aluResult;
    logic [rvDecodePkg::XLEN-1:0]   pcPlus4;
    logic [rvDecodePkg::XLEN-1:0]   pcTarget;
    logic [rvDecodePkg::XLEN-1:0]   pcNext;
    logic                           flagE;
    logic                           branchTaken;

    assign srcB        = ctrlD.aluSrc ? immExt : rs2Data;
    assign branchTaken = ctrlD.pcSrc != rvDecodePkg::PC_PLUS4; // any redirect

    control control_i (.opcodeD(instr.r.opcode), .flagE(flagE), .ctrlD(ctrlD));

    aluDecode aluDecode_i (.aluOp(ctrlD.aluOp), .funct3(instr.r.funct3),
        .funct7b5(instr.r.funct7[5]), .aluCtrl(aluCtrl), .branchCond(branchCond));

    immExtend immExtend_i (.instr(instr), .immSrc(ctrlD.immSrc), .immExt(immExt));

    alu alu_i (.srcA(rs1Data), .srcB(srcB), .aluCtrl(aluCtrl), .branchCond(branchCond),
        .aluResult(aluResult), .flagE(flagE));

    nextPc nextPc_i (.pc(pc), .immExt(immExt), .aluResult(aluResult), .pcSrc(ctrlD.pcSrc),
        .pcPlus4(pcPlus4), .pcTarget(pcTarget), .pcNext(pcNext));

    executeRegister executeRegister_i (.clk(clk), .reset(reset), .inValid(inValid),
        .ctrlD(ctrlD), .funct3(instr.r.funct3), .rd(instr.r.rd), .aluResult(aluResult),
        .writeData(rs2Data), .pcPlus4(pcPlus4), .pcTarget(pcTarget), .pcNext(pcNext),
        .branchTaken(branchTaken), .stage(stage));

endmodule

`default_nettype wire

// File: hw/executeRegister.sv
`default_nettype none

module executeRegister (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inValid,
    input  rvDecodePkg::ctrlT            ctrlD,
    input  logic [2:0]                   funct3,
    input  logic [4:0]                   rd,
    input  logic [rvDecodePkg::XLEN-1:0] aluResult,
    input  logic [rvDecodePkg::XLEN-1:0] writeData,
    input  logic [rvDecodePkg::XLEN-1:0] pcPlus4,
    input  logic [rvDecodePkg::XLEN-1:0] pcTarget,
    input  logic [rvDecodePkg::XLEN-1:0] pcNext,
    input  logic                         branchTaken,
    output rvDecodePkg::stageT           stage
);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0; // whole stage zero after reset
        end else begin
            stage.valid       <= inValid;
            stage.resultSrc   <= ctrlD.resultSrc;
            stage.memWrite    <= ctrlD.memWrite & inValid; // bubbles never write
            stage.regWrite    <= ctrlD.regWrite & inValid;
            stage.funct3      <= funct3;
            stage.rd          <= rd;
            stage.aluResult   <= aluResult;
            stage.writeData   <= writeData; // store data from rs2
            stage.pcPlus4     <= pcPlus4;
            stage.pcTarget    <= pcTarget;
            stage.pcNext      <= pcNext;
            stage.branchTaken <= branchTaken;
        end
    end

endmodule

`default_nettype wire

// File: hw/immExtend.sv
`default_nettype none

module immExtend (
    input  rvDecodePkg::instrT         instr,
    input  rvDecodePkg::immSrcT        immSrc,
    output logic [rvDecodePkg::XLEN-1:0] immExt
);

    always_comb begin
        case (immSrc)
            rvDecodePkg::IMM_S: begin
                immExt = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end
            rvDecodePkg::IMM_B: begin
                immExt = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                          instr.b.imm10to5, instr.b.imm4to1, 1'b0}; // even offset
            end
            rvDecodePkg::IMM_U: begin
                immExt = {instr.u.imm31to12, 12'b0}; // upper 20 bits
            end
            rvDecodePkg::IMM_J: begin
                immExt = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                          instr.j.imm11, instr.j.imm10to1, 1'b0};
            end
            default: begin
                immExt = {{20{instr.i.imm[11]}}, instr.i.imm}; // i-type and jalr
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/nextPc.sv
`default_nettype none

module nextPc (
    input  logic [rvDecodePkg::XLEN-1:0] pc,
    input  logic [rvDecodePkg::XLEN-1:0] immExt,
    input  logic [rvDecodePkg::XLEN-1:0] aluResult, // rs1 + imm for jalr
    input  rvDecodePkg::pcSrcT           pcSrc,
    output logic [rvDecodePkg::XLEN-1:0] pcPlus4,
    output logic [rvDecodePkg::XLEN-1:0] pcTarget,
    output logic [rvDecodePkg::XLEN-1:0] pcNext
);

    assign pcPlus4  = pc + rvDecodePkg::XLEN'(4);
    assign pcTarget = pc + immExt; // branch, jal, auipc

    always_comb begin
        case (pcSrc)
            rvDecodePkg::PC_TARGET: begin
                pcNext = pcTarget;
            end
            rvDecodePkg::PC_ALU: begin
                pcNext = {aluResult[rvDecodePkg::XLEN-1:1], 1'b0}; // jalr drops bit 0
            end
            default: begin
                pcNext = pcPlus4;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rvDecodePkg.sv
`default_nettype none

package rvDecodePkg;

    localparam int XLEN = 32; // data and address width

    // opcodes seen by the main decoder
    localparam logic [6:0] OP_R      = 7'b0110011; // register-register alu
    localparam logic [6:0] OP_IMM    = 7'b0010011; // register-immediate alu
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    typedef enum logic [2:0] {
        ALUOP_R      = 3'b000, // r-type
        ALUOP_I      = 3'b001, // i-type alu
        ALUOP_LOAD   = 3'b010,
        ALUOP_STORE  = 3'b011,
        ALUOP_BRANCH = 3'b100,
        ALUOP_JUMP   = 3'b101, // jal and jalr share this
        ALUOP_LUI    = 3'b110,
        ALUOP_AUIPC  = 3'b111
    } aluOpT;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10 // lui
    } aluCtrlT;

    // same encoding as branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branchCondT;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_TARGET = 2'b01, // pc + imm for taken branch or jal
        PC_ALU    = 2'b11  // jalr
    } pcSrcT;

    typedef enum logic [1:0] {
        RES_ALU    = 2'b00,
        RES_MEM    = 2'b01,
        RES_PC4    = 2'b10, // link value
        RES_TARGET = 2'b11  // auipc
    } resultSrcT;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_U = 3'b011,
        IMM_J = 3'b100
    } immSrcT;

    // instruction formats with msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo; // imm[4:0]
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm31to12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrT;

    typedef struct packed {
        pcSrcT     pcSrc;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      aluSrc;    // 1 selects immExt as srcB
        immSrcT    immSrc;
        logic      regWrite;
        aluOpT     aluOp;
    } ctrlT;

    typedef struct packed {
        logic            valid;
        resultSrcT       resultSrc;
        logic            memWrite;
        logic            regWrite;
        logic [2:0]      funct3;   // load/store width
        logic [4:0]      rd;
        logic [XLEN-1:0] aluResult;
        logic [XLEN-1:0] writeData;
        logic [XLEN-1:0] pcPlus4;
        logic [XLEN-1:0] pcTarget;
        logic [XLEN-1:0] pcNext;
        logic            branchTaken; // pc redirected away from pc+4
    } stageT;

endpackage

`default_nettype wire

// File: sim.f
hw/rvDecodePkg.sv
hw/control.sv
hw/aluDecode.sv
hw/immExtend.sv
hw/alu.sv
hw/nextPc.sv
hw/executeRegister.sv
hw/decodeExecute.sv
tb/decodeExecute_assertions.sv
tb/decodeExecuteTb.sv

// File: tb/decodeExecuteTb.sv
`default_nettype none

module decodeExecuteTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;  // after the rising edge
    localparam int RESET_CYCLES = 10;

    // one line of the pattern file
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs1Data;
        logic [31:0] rs2Data;
        logic [31:0] pc;
        logic [31:0] aluResult;
        logic [31:0] pcNext;
        logic [31:0] pcTarget;
        logic        regWrite;
        logic        memWrite;
        logic [1:0]  resultSrc;
    } vectorT;

    logic                         clk;
    logic                         reset;
    logic                         inValid;
    rvDecodePkg::instrT           instr;
    logic [rvDecodePkg::XLEN-1:0] rs1Data;
    logic [rvDecodePkg::XLEN-1:0] rs2Data;
    logic [rvDecodePkg::XLEN-1:0] pc;
    rvDecodePkg::stageT           stage;

    vectorT vectors[$];     // whole pattern file
    vectorT expQ[$];        // driven but not yet seen at the output
    int     driveCycleQ[$]; // cycle each queued vector was driven in
    int     cycle      = 0;
    int     checkCount = 0;
    int     seed       = 96;
    bit     loaded     = 1'b0;

    decodeExecute dut_i (
        .clk(clk),
        .reset(reset),
        .inValid(inValid),
        .instr(instr),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .pc(pc),
        .stage(stage)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1; // edge count read mid-cycle only
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            $display("mismatch at time %0d ns: %s expected %h got %h",
                     $time, what, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "%s", what);
        end
    endtask

    task automatic readPatterns();
        int          fd;
        int          count;
        string       line;
        logic [31:0] instrV, rs1V, rs2V, pcV, aluV, nextV, targetV;
        logic [3:0]  regW, memW, resSrc;
        fd = $fopen("tb/decodeExecute_patterns.txt", "r");
        if (fd == 0) begin
            abortRun("could not open tb/decodeExecute_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 8 || line[0] == "#") begin
                continue; // blank or column header
            end
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", instrV, rs1V, rs2V, pcV,
                            aluV, nextV, targetV, regW, memW, resSrc);
            if (count != 10) begin
                abortRun({"malformed pattern line: ", line});
            end
            vectors.push_back(vectorT'({instrV, rs1V, rs2V, pcV, aluV, nextV, targetV,
                                        regW[0], memW[0], resSrc[1:0]}));
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            abortRun("pattern file holds no vectors");
        end
    endtask

    // driver
    initial begin
        int gap;
        reset   = 1'b1;
        inValid = 1'b0;
        instr   = '0;
        rs1Data = '0;
        rs2Data = '0;
        pc      = '0;
        readPatterns();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        repeat (2) begin
            @(posedge clk); // a couple of idle cycles out of reset
            #DRIVE_DELAY;
        end
        foreach (vectors[k]) begin
            gap     = int'($unsigned($random(seed)) % 3); // 0..2 bubbles
            inValid = 1'b0;
            repeat (gap) begin
                instr = rvDecodePkg::instrT'($random(seed)); // junk must not write
                @(posedge clk);
                #DRIVE_DELAY;
            end
            instr   = rvDecodePkg::instrT'(vectors[k].instr);
            rs1Data = vectors[k].rs1Data;
            rs2Data = vectors[k].rs2Data;
            pc      = vectors[k].pc;
            inValid = 1'b1;
            expQ.push_back(vectors[k]);
            driveCycleQ.push_back(cycle);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        inValid = 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk); // drain the stage register
        end
        repeat (3) @(posedge clk);
        if (checkCount == 0 || dut_i.assertions_i.failCount != 0) begin
            abortRun("run ended with no checks done or with failed assertions");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // checker sampling mid-cycle
    initial begin
        vectorT want;
        int     driven;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (reset) begin
                checkValue(32'(stage == '0), 32'd1, "stage cleared during reset");
            end else if (!stage.valid) begin
                checkValue(32'(stage.regWrite), 32'd0, "regWrite on an idle cycle");
                checkValue(32'(stage.memWrite), 32'd0, "memWrite on an idle cycle");
            end else begin
                if (expQ.size() == 0) begin
                    abortRun("stage valid with no instruction outstanding");
                end
                want   = expQ.pop_front();
                driven = driveCycleQ.pop_front();
                checkValue(cycle - driven, 1, $sformatf("latency for pc %h", want.pc));
                checkValue(stage.aluResult, want.aluResult,
                           $sformatf("aluResult for pc %h", want.pc));
                checkValue(stage.pcNext, want.pcNext, $sformatf("pcNext for pc %h", want.pc));
                checkValue(stage.pcTarget, want.pcTarget,
                           $sformatf("pcTarget for pc %h", want.pc));
                checkValue(stage.pcPlus4, want.pc + 32'd4, "pcPlus4");
                checkValue(stage.writeData, want.rs2Data, "writeData is rs2");
                checkValue(32'(stage.rd), 32'(want.instr[11:7]), "rd field");
                checkValue(32'(stage.funct3), 32'(want.instr[14:12]), "funct3 field");
                checkValue(32'(stage.regWrite), 32'(want.regWrite),
                           $sformatf("regWrite for pc %h", want.pc));
                checkValue(32'(stage.memWrite), 32'(want.memWrite),
                           $sformatf("memWrite for pc %h", want.pc));
                checkValue(32'(stage.resultSrc), 32'(want.resultSrc),
                           $sformatf("resultSrc for pc %h", want.pc));
                // redirect whenever the next pc is not pc+4
                checkValue(32'(stage.branchTaken), 32'(want.pcNext != want.pc + 32'd4),
                           $sformatf("branchTaken for pc %h", want.pc));
            end
        end
    end

    // watchdog sized from the vector count
    initial begin
        int limit;
        wait (loaded);
        limit = vectors.size() * 4 + 30;
        repeat (limit) @(posedge clk);
        abortRun($sformatf("timeout: run did not finish within %0d clock cycles", limit));
    end

endmodule

`default_nettype wire

// File: tb/decodeExecute_assertions.sv
`default_nettype none

module decodeExecuteAssertions (
    input logic               clk,
    input logic               reset,
    input logic               inValid,
    input rvDecodePkg::stageT stage
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0; // failed assertions so far

    validAfterReset: assert property (@(posedge clk) reset |=> !stage.valid)
        else begin
            failCount++;
            $error("stage valid in the cycle after reset");
        end

    // one-cycle copy of inValid
    validFollowsInput: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> stage.valid == $past(inValid))
        else begin
            failCount++;
            $error("stage valid does not follow inValid of the previous cycle");
        end

    writesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(stage.memWrite && stage.regWrite))
        else begin
            failCount++;
            $error("memWrite and regWrite high together");
        end

endmodule

bind decodeExecute decodeExecuteAssertions assertions_i (
    .clk(clk),
    .reset(reset),
    .inValid(inValid),
    .stage(stage)
);

`default_nettype wire

// File: tb/decodeExecute_patterns.txt
# instr rs1Data rs2Data pc | expected aluResult pcNext pcTarget regWrite memWrite resultSrc
# all fields hex, one vector per line
002082B3 00000005 00000007 00001000 0000000C 00001004 00001002 1 0 0
402082B3 00000005 00000007 00001004 FFFFFFFE 00001008 00001406 1 0 0
4020D2B3 80000010 00000004 00001008 F8000001 0000100C 0000140A 1 0 0
0020A2B3 FFFFFFFF 00000001 0000100C 00000001 00001010 0000100E 1 0 0
0020B2B3 FFFFFFFF 00000001 00001010 00000000 00001014 00001012 1 0 0
FFD08293 0000000A 12345678 00001014 00000007 00001018 00001011 1 0 0
4030D293 80000000 00000000 00001018 F0000000 0000101C 0000141B 1 0 0
00409293 0000000F 00000000 0000101C 000000F0 00001020 00001020 1 0 0
FFC0A283 00002000 00000000 00001020 00001FFC 00001024 0000101C 1 0 1
FE20AC23 00003000 CAFEBABE 00001024 00002FF8 00001028 0000101C 0 1 0
00208863 00000005 00000005 00001100 00000000 00001110 00001110 0 0 0
00208863 00000005 00000006 00001104 FFFFFFFF 00001108 00001114 0 0 0
FE209CE3 00000005 00000006 00001108 FFFFFFFF 00001100 00001100 0 0 0
00209863 00000007 00000007 0000110C 00000000 00001110 0000111C 0 0 0
0020C863 FFFFFFFE 00000001 00001110 FFFFFFFD 00001120 00001120 0 0 0
0020C863 00000001 FFFFFFFE 00001114 00000003 00001118 00001124 0 0 0
0020D863 00000001 FFFFFFFE 00001118 00000003 00001128 00001128 0 0 0
0020D863 FFFFFFFE 00000001 0000111C FFFFFFFD 00001120 0000112C 0 0 0
0020E863 00000001 FFFFFFFE 00001120 00000003 00001130 00001130 0 0 0
0020E863 FFFFFFFE 00000001 00001124 FFFFFFFD 00001128 00001134 0 0 0
0020F863 FFFFFFFE 00000001 00001128 FFFFFFFD 00001138 00001138 0 0 0
0020F863 00000001 FFFFFFFE 0000112C 00000003 00001130 0000113C 0 0 0
100000EF 00000000 00000000 00001200 00000100 00001300 00001300 1 0 2
004080E7 00002001 00000000 00001204 00002005 00002004 00001208 1 0 2
123452B7 DEADBEEF 00000000 00001208 12345000 0000120C 12346208 1 0 0
FFFFF297 00001000 00000000 0000320C 00000000 00003210 0000220C 1 0 3
002082FF 00000003 00000004 00001210 00000007 00001214 00001212 0 0 0
